//--- hdl/hack_params.svh
`ifndef HACK_PARAMS_SVH
`define HACK_PARAMS_SVH

// data and instruction words share one width
`define HACK_WORD_W      16
// ROM and RAM are both addressed by the low bits of a word
`define HACK_ADDR_W      15

// queue entries, which is also the number of credits fetch starts with
`define HACK_QUEUE_DEPTH 4
// must hold the full credit count, so one bit more than the queue pointer
`define HACK_CREDIT_W    3

// ********************
// instruction fields
// ********************

// set for a C-instruction, clear for an A-instruction
`define HACK_BIT_C       15
// C-instruction takes M instead of A as the ALU y operand
`define HACK_BIT_AM      12
// low bit of the six ALU control bits zx nx zy ny f no
`define HACK_FN_LSB      6
// destinations
`define HACK_BIT_LD_A    5
`define HACK_BIT_LD_D    4
`define HACK_BIT_LD_M    3
// jump conditions on the ALU result
`define HACK_BIT_LT      2
`define HACK_BIT_EQ      1
`define HACK_BIT_GT      0

`endif

//--- hdl/hack_pkg.sv
`include "hack_params.svh"

package hack_pkg;

    // a data word on the RAM bus or an instruction word from the ROM
    typedef logic [`HACK_WORD_W-1:0] word_t;

    // a ROM or RAM address
    typedef logic [`HACK_ADDR_W-1:0] addr_t;

    // ALU control bits, zx in the msb down to no in the lsb, in instruction order
    typedef logic [5:0] alu_fn_t;

    // outstanding credits between fetch and the instruction queue
    typedef logic [`HACK_CREDIT_W-1:0] credit_t;

    // fetch runs sequentially, or spends one cycle restarting after a flush
    typedef enum logic {
        FETCH_RUN,
        FETCH_REDIRECT
    } fetch_state_t;

endpackage

//--- hdl/hack_ifs.sv
// fetch to queue bundle
// flush comes from execute but reaches both fetch and queue here
interface fetch_if;
    import hack_pkg::*;

    logic  push;
    word_t inst;
    addr_t addr;
    logic  credit_return;
    logic  flush;

    modport fetch (output push, inst, addr, input credit_return, flush);
    modport queue (input push, inst, addr, flush, output credit_return);
    modport exec  (output flush);
endinterface

// queue to execute bundle
// exec pops in every cycle where valid is high
interface issue_if;
    import hack_pkg::*;

    logic  valid;
    word_t inst;
    addr_t addr;
    logic  pop;

    modport queue (output valid, inst, addr, input pop);
    modport exec  (input valid, inst, addr, output pop);
endinterface

//--- hdl/hack_alu.sv
`include "hack_params.svh"

module hack_alu (
    input  hack_pkg::word_t   x,
    input  hack_pkg::word_t   y,
    input  hack_pkg::alu_fn_t fn,
    output hack_pkg::word_t   result,
    output logic              zero,
    output logic              neg
);
    import hack_pkg::*;

    word_t x_zeroed;
    word_t x_op;
    word_t y_zeroed;
    word_t y_op;
    word_t raw;

    // fn[5] zx and fn[4] nx condition the x operand
    assign x_zeroed = fn[5] ? '0 : x;
    assign x_op     = fn[4] ? ~x_zeroed : x_zeroed;

    // fn[3] zy and fn[2] ny do the same for y
    assign y_zeroed = fn[3] ? '0 : y;
    assign y_op     = fn[2] ? ~y_zeroed : y_zeroed;

    // fn[1] picks add over bitwise and, fn[0] inverts the output
    assign raw    = fn[1] ? (x_op + y_op) : (x_op & y_op);
    assign result = fn[0] ? ~raw : raw;

    // flags feed the jump decision in execute
    assign zero = (result == '0);
    assign neg  = result[`HACK_WORD_W-1];

endmodule

//--- hdl/hack_regs.sv
`include "hack_params.svh"

module hack_regs (
    input  logic            clk,
    input  logic            resetN,
    input  logic            load_a,
    input  logic            load_d,
    input  hack_pkg::word_t a_next,
    input  hack_pkg::word_t d_next,
    output hack_pkg::word_t a_val,
    output hack_pkg::word_t d_val,
    output hack_pkg::addr_t data_addr
);
    import hack_pkg::*;

    word_t a_q;
    word_t d_q;

    // A holds either a constant or an ALU result, D only ALU results
    always_ff @(posedge clk or negedge resetN)
    begin
        if (!resetN)
        begin
            a_q <= '0;
            d_q <= '0;
        end
        else
        begin
            if (load_a)
                a_q <= a_next;
            if (load_d)
                d_q <= d_next;
        end
    end

    assign a_val = a_q;
    assign d_val = d_q;

    // the RAM is addressed by A for both the M read and the M write
    assign data_addr = a_q[`HACK_ADDR_W-1:0];

endmodule

//--- hdl/inst_fetch.sv
`include "hack_params.svh"

module inst_fetch (
    input  logic            clk,
    input  logic            resetN,
    output hack_pkg::addr_t rom_addr,
    input  hack_pkg::word_t rom_data,
    input  hack_pkg::addr_t redirect_addr,
    fetch_if.fetch          fq
);
    import hack_pkg::*;

    fetch_state_t state;
    addr_t        fetch_addr;
    addr_t        req_addr_q;
    credit_t      credits;
    logic         in_flight;
    logic         req;

    // a request needs a free queue slot, except in the redirect cycle
    // where the queue was just emptied and the whole window is free again
    assign req = (state == FETCH_REDIRECT) || (credits != '0);

    // the ROM sees the fetch address directly, data comes back a cycle later
    assign rom_addr = fetch_addr;

    // ********************
    // fetch state
    // ********************

    always_ff @(posedge clk or negedge resetN)
    begin
        if (!resetN)
        begin
            state      <= FETCH_RUN;
            fetch_addr <= '0;
            credits    <= credit_t'(`HACK_QUEUE_DEPTH);
            in_flight  <= 1'b0;
        end
        else if (fq.flush)
        begin
            // the word now in flight belongs to the wrong path, so drop it
            state      <= FETCH_REDIRECT;
            fetch_addr <= redirect_addr;
            in_flight  <= 1'b0;
        end
        else
        begin
            state      <= FETCH_RUN;
            in_flight  <= req;
            if (req)
                fetch_addr <= fetch_addr + addr_t'(1);
            // after a flush the queue is empty, so the counter restarts full
            // minus the request going out to the target in this cycle
            if (state == FETCH_REDIRECT)
                credits <= credit_t'(`HACK_QUEUE_DEPTH - 1);
            else
                credits <= credits - credit_t'(req) + credit_t'(fq.credit_return);
        end
    end

    // address of the request in flight travels with its ROM word
    always_ff @(posedge clk)
    begin
        if (req)
            req_addr_q <= fetch_addr;
    end

    assign fq.push = in_flight;
    assign fq.inst = rom_data;
    assign fq.addr = req_addr_q;

endmodule

//--- hdl/inst_queue.sv
`include "hack_params.svh"

module inst_queue (
    input  logic   clk,
    input  logic   resetN,
    fetch_if.queue fq,
    issue_if.queue iq
);
    import hack_pkg::*;

    localparam int PTR_W = $clog2(`HACK_QUEUE_DEPTH);

    word_t            inst_mem [`HACK_QUEUE_DEPTH];
    addr_t            addr_mem [`HACK_QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    credit_t          count;
    logic             do_pop;

    // pointer step with explicit wrap so any depth works
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(`HACK_QUEUE_DEPTH - 1))
            return '0;
        return ptr + PTR_W'(1);
    endfunction

    // a pop against an empty queue is ignored
    assign do_pop = iq.pop && (count != '0);

    // every consumed entry frees a slot for fetch
    // on a flush fetch rebuilds its credits itself, so nothing is returned
    assign fq.credit_return = do_pop && !fq.flush;

    always_ff @(posedge clk or negedge resetN)
    begin
        if (!resetN)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else if (fq.flush)
        begin
            // wrong-path entries and any push in this cycle are thrown away
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (fq.push)
                wr_ptr <= ptr_inc(wr_ptr);
            if (do_pop)
                rd_ptr <= ptr_inc(rd_ptr);
            count <= count + credit_t'(fq.push) - credit_t'(do_pop);
        end
    end

    // storage, overflow cannot happen because fetch only pushes on credit
    always_ff @(posedge clk)
    begin
        if (fq.push)
        begin
            inst_mem[wr_ptr] <= fq.inst;
            addr_mem[wr_ptr] <= fq.addr;
        end
    end

    assign iq.valid = (count != '0);
    assign iq.inst  = inst_mem[rd_ptr];
    assign iq.addr  = addr_mem[rd_ptr];

endmodule

//--- hdl/exec_unit.sv
`include "hack_params.svh"

module exec_unit (
    input  logic            clk,
    input  logic            resetN,
    issue_if.exec           iq,
    fetch_if.exec           fq,
    input  hack_pkg::word_t a_val,
    input  hack_pkg::word_t d_val,
    input  hack_pkg::word_t in_m,
    output logic            load_a,
    output logic            load_d,
    output hack_pkg::word_t a_next,
    output hack_pkg::word_t d_next,
    output hack_pkg::addr_t redirect_addr,
    output hack_pkg::word_t out_m,
    output logic            write_m
);
    import hack_pkg::*;

    word_t   inst;
    word_t   y_op;
    word_t   alu_result;
    alu_fn_t fn;
    addr_t   jump_target;
    addr_t   seq_addr;
    logic    is_c;
    logic    fire;
    logic    zero;
    logic    neg;
    logic    cond_match;
    logic    flush_q;

    // ********************
    // decode
    // ********************

    assign inst = iq.inst;
    assign is_c = inst[`HACK_BIT_C];
    assign fn   = inst[`HACK_FN_LSB +: $bits(alu_fn_t)];

    // the queue head is consumed in every cycle it is valid
    assign iq.pop = iq.valid;

    // a flush keeps execution off for one cycle, so the flush is a single pulse
    assign fire = iq.valid && !flush_q;

    always_ff @(posedge clk or negedge resetN)
    begin
        if (!resetN)
            flush_q <= 1'b0;
        else
            flush_q <= fq.flush;
    end

    // y operand is A or the RAM word that A currently points at
    assign y_op = inst[`HACK_BIT_AM] ? in_m : a_val;

    hack_alu alu_i (
        .x      (d_val),
        .y      (y_op),
        .fn     (fn),
        .result (alu_result),
        .zero   (zero),
        .neg    (neg)
    );

    // ********************
    // destinations
    // ********************

    // an A-instruction always loads its 15-bit constant into A
    assign load_a  = fire && (!is_c || inst[`HACK_BIT_LD_A]);
    assign load_d  = fire && is_c && inst[`HACK_BIT_LD_D];
    assign write_m = fire && is_c && inst[`HACK_BIT_LD_M];

    assign a_next = is_c ? alu_result : word_t'(inst[`HACK_ADDR_W-1:0]);
    assign d_next = alu_result;
    assign out_m  = alu_result;

    // ********************
    // jumps
    // ********************

    // greater than zero is neither negative nor zero
    assign cond_match = (inst[`HACK_BIT_LT] && neg) ||
                        (inst[`HACK_BIT_EQ] && zero) ||
                        (inst[`HACK_BIT_GT] && !neg && !zero);

    // target is A before this instruction writes it, as in the Hack CPU
    assign jump_target   = a_val[`HACK_ADDR_W-1:0];
    assign redirect_addr = jump_target;

    // fetch already runs down the fall-through path, so a jump to the next
    // address needs no flush
    assign seq_addr = iq.addr + addr_t'(1);

    assign fq.flush = fire && is_c && cond_match && (jump_target != seq_addr);

endmodule

//--- hdl/hack_cpu.sv
module hack_cpu (
    input  logic            clk,
    input  logic            resetN,
    output hack_pkg::addr_t inst_addr,
    input  hack_pkg::word_t inst,
    output hack_pkg::addr_t data_addr,
    input  hack_pkg::word_t in_m,
    output hack_pkg::word_t out_m,
    output logic            write_m
);
    import hack_pkg::*;

    word_t a_val;
    word_t d_val;
    word_t a_next;
    word_t d_next;
    addr_t redirect_addr;
    logic  load_a;
    logic  load_d;

    // fetch pushes into the queue, execute flushes both of them
    fetch_if fq_bus ();
    // queue head handed to execute
    issue_if iq_bus ();

    inst_fetch fetch_i (
        .clk           (clk),
        .resetN        (resetN),
        .rom_addr      (inst_addr),
        .rom_data      (inst),
        .redirect_addr (redirect_addr),
        .fq            (fq_bus.fetch)
    );

    inst_queue queue_i (
        .clk    (clk),
        .resetN (resetN),
        .fq     (fq_bus.queue),
        .iq     (iq_bus.queue)
    );

    exec_unit exec_i (
        .clk           (clk),
        .resetN        (resetN),
        .iq            (iq_bus.exec),
        .fq            (fq_bus.exec),
        .a_val         (a_val),
        .d_val         (d_val),
        .in_m          (in_m),
        .load_a        (load_a),
        .load_d        (load_d),
        .a_next        (a_next),
        .d_next        (d_next),
        .redirect_addr (redirect_addr),
        .out_m         (out_m),
        .write_m       (write_m)
    );

    // A also addresses the data RAM
    hack_regs regs_i (
        .clk       (clk),
        .resetN    (resetN),
        .load_a    (load_a),
        .load_d    (load_d),
        .a_next    (a_next),
        .d_next    (d_next),
        .a_val     (a_val),
        .d_val     (d_val),
        .data_addr (data_addr)
    );

endmodule

//--- test/tb_hack_model.svh
`ifndef TB_HACK_MODEL_SVH
`define TB_HACK_MODEL_SVH

// ********************
// Hack instruction set
// ********************

// comp fields of the Hack instruction set, the a bit is kept apart
localparam logic [5:0] C_ZERO  = 6'b101010;
localparam logic [5:0] C_ONE   = 6'b111111;
localparam logic [5:0] C_NEG1  = 6'b111010;
localparam logic [5:0] C_D     = 6'b001100;
localparam logic [5:0] C_A     = 6'b110000;
localparam logic [5:0] C_NOTD  = 6'b001101;
localparam logic [5:0] C_NOTA  = 6'b110001;
localparam logic [5:0] C_NEGD  = 6'b001111;
localparam logic [5:0] C_NEGA  = 6'b110011;
localparam logic [5:0] C_DINC  = 6'b011111;
localparam logic [5:0] C_AINC  = 6'b110111;
localparam logic [5:0] C_DDEC  = 6'b001110;
localparam logic [5:0] C_ADEC  = 6'b110010;
localparam logic [5:0] C_DPA   = 6'b000010;
localparam logic [5:0] C_DMA   = 6'b010011;
localparam logic [5:0] C_AMD   = 6'b000111;
localparam logic [5:0] C_DANDA = 6'b000000;
localparam logic [5:0] C_DORA  = 6'b010101;

// the legal table that random programs draw from
localparam int N_COMPS = 18;
localparam logic [5:0] COMP_TABLE [N_COMPS] = '{
    C_ZERO, C_ONE, C_NEG1, C_D, C_A, C_NOTD, C_NOTA, C_NEGD, C_NEGA,
    C_DINC, C_AINC, C_DDEC, C_ADEC, C_DPA, C_DMA, C_AMD, C_DANDA, C_DORA
};

// destination bits are A, D, M from msb to lsb
localparam logic [2:0] DST_NONE = 3'b000;
localparam logic [2:0] DST_M    = 3'b001;
localparam logic [2:0] DST_D    = 3'b010;
localparam logic [2:0] DST_MD   = 3'b011;

// jump bits are lt, eq, gt from msb to lsb
localparam logic [2:0] J_NONE = 3'b000;
localparam logic [2:0] J_GT   = 3'b001;
localparam logic [2:0] J_EQ   = 3'b010;
localparam logic [2:0] J_JMP  = 3'b111;

// x^32 + x^22 + x^2 + x + 1, one step per bit taken
logic [31:0] lfsr_state = 32'hac3a;

// data memory of the reference model, rebuilt for every program
word_t model_ram [RAM_WORDS];

function automatic logic next_lfsr_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
endfunction

// gathers n fresh bits, first bit ends up most significant
function automatic logic [31:0] random_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
        v = {v[30:0], next_lfsr_bit()};
    return v;
endfunction

// starting RAM image, the two marked words are preloads for the M operand test
function automatic word_t ram_fill(input addr_t addr);
    case (addr)
        15'd200: return 16'h1234;
        15'd202: return 16'h0f0f;
        default: return {1'b0, addr} ^ 16'h5a3c;
    endcase
endfunction

// value of each comp mnemonic as the Hack language defines it
function automatic word_t hack_comp_value(input logic [5:0] comp, input word_t d, input word_t y);
    case (comp)
        C_ZERO:  return '0;
        C_ONE:   return 16'd1;
        C_NEG1:  return '1;
        C_D:     return d;
        C_A:     return y;
        C_NOTD:  return ~d;
        C_NOTA:  return ~y;
        C_NEGD:  return -d;
        C_NEGA:  return -y;
        C_DINC:  return d + 16'd1;
        C_AINC:  return y + 16'd1;
        C_DDEC:  return d - 16'd1;
        C_ADEC:  return y - 16'd1;
        C_DPA:   return d + y;
        C_DMA:   return d - y;
        C_AMD:   return y - d;
        C_DANDA: return d & y;
        C_DORA:  return d | y;
        default: return 'x;
    endcase
endfunction

// ********************
// reference run
// ********************

// executes program t until it reaches its halt loop and lists every RAM store
task automatic reference_run(input int t);
    word_t a;
    word_t d;
    word_t iw;
    word_t y;
    word_t res;
    addr_t a_old;
    logic  take;
    int    pc;
    int    n;
    for (int i = 0; i < RAM_WORDS; i++)
        model_ram[i] = ram_fill(addr_t'(i));
    a = '0;
    d = '0;
    pc = 0;
    n = 0;
    exp_count[t] = 0;
    while (pc != prog_halt[t] && n < MAX_STEPS)
    begin
        iw = (pc < PROG_WORDS) ? rom_img[t][pc] : '0;
        n++;
        if (!iw[15])
        begin
            a = iw;
            pc++;
        end
        else
        begin
            // both the M operand and the jump target use A before this instruction
            a_old = a[14:0];
            y = iw[12] ? model_ram[a_old] : a;
            res = hack_comp_value(iw[11:6], d, y);
            take = (iw[2] && res[15]) || (iw[1] && res == '0) ||
                   (iw[0] && !res[15] && res != '0);
            if (iw[3])
            begin
                model_ram[a_old] = res;
                if (exp_count[t] < MAX_WR)
                begin
                    exp_addr[t][exp_count[t]] = a_old;
                    exp_data[t][exp_count[t]] = res;
                    exp_count[t]++;
                end
                else
                begin
                    model_errors++;
                    $display("test %0d stores more often than the list can hold", t);
                end
            end
            if (iw[4])
                d = res;
            if (iw[5])
                a = res;
            pc = take ? int'(a_old) : pc + 1;
        end
    end
    steps[t] = n;
    if (pc != prog_halt[t])
    begin
        model_errors++;
        $display("reference model of test %0d never reached its halt loop", t);
    end
endtask

`endif

//--- test/tb_hack_cpu.sv
`include "hack_params.svh"

module tb_hack_cpu;
    import hack_pkg::*;

    localparam int N_TESTS      = 6;
    localparam int PROG_WORDS   = 64;
    localparam int RAND_LEN     = 48;
    localparam int MAX_WR       = 64;
    localparam int MAX_STEPS    = 4000;
    localparam int RESET_CYCLES = 16;
    localparam int DRAIN_CYCLES = 16;
    localparam int RAM_WORDS    = 1 << `HACK_ADDR_W;

    // the clock starts high so that the first edge is a falling one and
    // reset reaches the CPU before any rising edge
    logic  clk    = 1'b1;
    logic  resetN = 1'b1;
    addr_t inst_addr;
    word_t inst   = '0;
    addr_t data_addr;
    word_t in_m;
    word_t out_m;
    logic  write_m;

    // program images and the store lists the reference model predicts for them
    word_t rom_img   [N_TESTS][PROG_WORDS];
    int    prog_halt [N_TESTS];
    addr_t exp_addr  [N_TESTS][MAX_WR];
    word_t exp_data  [N_TESTS][MAX_WR];
    int    exp_count [N_TESTS];
    int    steps     [N_TESTS];
    string test_name [N_TESTS];

    word_t ram [RAM_WORDS];
    word_t rom_next     = '0;
    int    cur          = 0;
    int    wr_idx       = 0;
    int    errors       = 0;
    int    model_errors = 0;
    int    limit_cycles = 0;
    int    build_t;
    int    build_pc;

    `include "tb_hack_model.svh"

    hack_cpu uut (
        .clk       (clk),
        .resetN    (resetN),
        .inst_addr (inst_addr),
        .inst      (inst),
        .data_addr (data_addr),
        .in_m      (in_m),
        .out_m     (out_m),
        .write_m   (write_m)
    );

    initial
    begin
        forever #20 clk = ~clk;
    end

    // ********************
    // memory models
    // ********************

    // ROM word for the address of one cycle shows up at the falling edge of the next
    always @(negedge clk)
    begin
        inst     <= rom_next;
        rom_next <= (inst_addr < PROG_WORDS) ? rom_img[cur][inst_addr] : '0;
    end

    // the RAM reads without a clock because the CPU expects M in the same cycle as A
    assign in_m = ram[data_addr];

    // reset restores the RAM image and wr_idx then points at the next expected store
    always @(posedge clk)
    begin
        if (!resetN)
        begin
            wr_idx <= 0;
            for (int i = 0; i < RAM_WORDS; i++)
                ram[i] <= ram_fill(addr_t'(i));
        end
        else if (write_m)
        begin
            wr_idx <= wr_idx + 1;
            ram[data_addr] <= out_m;
        end
    end

    // ********************
    // store checks
    // ********************

    reset_quiet: assert property (@(posedge clk) !resetN |-> !write_m)
    else
    begin
        errors++;
        $display("write_m was high while resetN was low");
    end

    // catches a store past the end of the predicted list
    store_expected: assert property (@(posedge clk) disable iff (!resetN)
        write_m |-> wr_idx < exp_count[cur])
    else
    begin
        errors++;
        $display("unexpected store to %h with data %h", $sampled(data_addr), $sampled(out_m));
    end

    store_addr: assert property (@(posedge clk) disable iff (!resetN)
        write_m && wr_idx < exp_count[cur] |-> data_addr == exp_addr[cur][wr_idx])
    else
    begin
        errors++;
        $display("mismatch data_addr: got %h, expected %h",
                 $sampled(data_addr), $sampled(exp_addr[cur][wr_idx]));
    end

    store_data: assert property (@(posedge clk) disable iff (!resetN)
        write_m && wr_idx < exp_count[cur] |-> out_m == exp_data[cur][wr_idx])
    else
    begin
        errors++;
        $display("mismatch out_m: got %h, expected %h",
                 $sampled(out_m), $sampled(exp_data[cur][wr_idx]));
    end

    // ********************
    // program builder
    // ********************

    task automatic begin_program(input int t, input string name);
        build_t      = t;
        build_pc     = 0;
        test_name[t] = name;
        for (int i = 0; i < PROG_WORDS; i++)
            rom_img[t][i] = '0;
    endtask

    task automatic put_const(input int value);
        rom_img[build_t][build_pc] = {1'b0, 15'(value)};
        build_pc++;
    endtask

    task automatic put_compute(input logic am, input logic [5:0] comp,
                               input logic [2:0] dest, input logic [2:0] jump);
        rom_img[build_t][build_pc] = {3'b111, am, comp, dest, jump};
        build_pc++;
    endtask

    // @addr then M=D
    task automatic store_d(input int addr);
        put_const(addr);
        put_compute(1'b0, C_D, DST_M, J_NONE);
    endtask

    // programs end in a loop that jumps to itself and never stores again
    task automatic end_with_halt();
        prog_halt[build_t] = build_pc;
        put_const(build_pc);
        put_compute(1'b0, C_ZERO, DST_NONE, J_JMP);
    endtask

    task automatic build_programs();
        logic       am;
        logic [5:0] comp;
        logic [2:0] dest;
        int         konst;
        int         loop_top;
        // straight ALU operations on D and A with each result stored
        begin_program(0, "alu");
        put_const(16'h1234);
        put_compute(1'b0, C_A, DST_D, J_NONE);
        store_d(100);
        put_const(16'h0101);
        put_compute(1'b0, C_DPA, DST_D, J_NONE);
        store_d(101);
        put_const(16'h0035);
        put_compute(1'b0, C_DMA, DST_D, J_NONE);
        store_d(102);
        put_const(16'h7f0f);
        put_compute(1'b0, C_DANDA, DST_D, J_NONE);
        store_d(103);
        put_const(16'h00ff);
        put_compute(1'b0, C_DORA, DST_D, J_NONE);
        store_d(104);
        put_compute(1'b0, C_NOTD, DST_D, J_NONE);
        store_d(105);
        put_compute(1'b0, C_NEG1, DST_D, J_NONE);
        store_d(106);
        end_with_halt();
        // the M read right after M=M+1 must see the new value
        begin_program(1, "memory");
        put_const(200);
        put_compute(1'b1, C_AINC, DST_M, J_NONE);
        put_compute(1'b1, C_A, DST_D, J_NONE);
        store_d(201);
        put_const(202);
        put_compute(1'b1, C_DPA, DST_MD, J_NONE);
        store_d(203);
        end_with_halt();
        // countdown from 5 with JGT and then a JEQ that must fall through
        begin_program(2, "loop");
        put_const(5);
        put_compute(1'b0, C_A, DST_D, J_NONE);
        loop_top = build_pc;
        store_d(100);
        put_const(loop_top);
        put_compute(1'b0, C_DDEC, DST_D, J_GT);
        put_const(build_pc + 4);
        put_compute(1'b0, C_DINC, DST_D, J_EQ);
        store_d(101);
        end_with_halt();
        // random straight-line code
        for (int t = 3; t < N_TESTS; t++)
        begin
            begin_program(t, "random");
            for (int i = 0; i < RAND_LEN; i++)
            begin
                if (random_bits(1) == 1)
                begin
                    konst = int'(random_bits(15));
                    put_const(konst);
                end
                else
                begin
                    am   = (random_bits(1) != 0);
                    comp = COMP_TABLE[random_bits(5) % N_COMPS];
                    dest = 3'(random_bits(3));
                    put_compute(am, comp, dest, J_NONE);
                end
            end
            end_with_halt();
        end
    endtask

    // holds reset, releases it and waits until the last predicted store has been seen
    task automatic run_test(input int t);
        int err_start;
        @(negedge clk);
        resetN = 1'b0;
        cur    = t;
        repeat (RESET_CYCLES) @(negedge clk);
        err_start = errors;
        resetN    = 1'b1;
        while (wr_idx < exp_count[t])
            @(negedge clk);
        // a few more cycles so that a stray store after the list is caught
        repeat (DRAIN_CYCLES) @(negedge clk);
        $display("test %0d %s: %0d of %0d stores seen, %0d errors",
                 t, test_name[t], wr_idx, exp_count[t], errors - err_start);
    endtask

    initial
    begin
        int total_steps;
        total_steps = 0;
        build_programs();
        for (int t = 0; t < N_TESTS; t++)
        begin
            reference_run(t);
            total_steps += steps[t];
        end
        limit_cycles = total_steps * 8 + N_TESTS * (RESET_CYCLES + DRAIN_CYCLES + 2);
        for (int t = 0; t < N_TESTS; t++)
            run_test(t);
        $display("%0d tests run, %0d checks failed", N_TESTS, errors + model_errors);
        if (errors == 0 && model_errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

    // the watchdog is armed once the model has counted the steps of every program
    initial
    begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        $display("timeout after %0d cycles, the expected stores did not all arrive",
                 limit_cycles);
        $display("Testbench failed");
        $finish;
    end

endmodule

//--- sources.f
+incdir+hdl
+incdir+test
hdl/hack_pkg.sv
hdl/hack_ifs.sv
hdl/hack_alu.sv
hdl/hack_regs.sv
hdl/inst_fetch.sv
hdl/inst_queue.sv
hdl/exec_unit.sv
hdl/hack_cpu.sv
test/tb_hack_cpu.sv

//--- Bender.yml
package:
  name: hack_cpu

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/hack_pkg.sv
      - hdl/hack_ifs.sv
      - hdl/hack_alu.sv
      - hdl/hack_regs.sv
      - hdl/inst_fetch.sv
      - hdl/inst_queue.sv
      - hdl/exec_unit.sv
      - hdl/hack_cpu.sv
  - target: test
    include_dirs:
      - hdl
      - test
    files:
      - test/tb_hack_cpu.sv
